/* logic/hci_pkg.sv */
// Shared widths, plain vector typedefs and the selection FSM states.

package hci_pkg;

  // ==========================================================================
  // Widths
  // ==========================================================================

  localparam int unsigned NB_CHAN   = 2;    // Initiator channels.
  localparam int unsigned SEL_W     = 1;    // Channel select width.
  localparam int unsigned DATA_W    = 32;   // Data word width.
  localparam int unsigned BE_W      = 4;    // One enable per byte.
  localparam int unsigned ADDR_W    = 10;   // Byte address width.
  localparam int unsigned MEM_WORDS = 256;  // Bank depth in words.
  localparam int unsigned ID_W      = 2;    // Transaction id width.
  localparam int unsigned OUTST_W   = 2;    // Outstanding counter width.

  // ==========================================================================
  // Vector types
  // ==========================================================================

  typedef logic [DATA_W-1:0] data_t;  // One data word.
  typedef logic [BE_W-1:0]   be_t;    // Byte enables of one word.
  typedef logic [ADDR_W-1:0] addr_t;  // Byte address.
  typedef logic [ID_W-1:0]   id_t;    // Transaction id.
  typedef logic [SEL_W-1:0]  sel_t;   // Channel select.

  // Selection controller states.
  typedef enum logic {
    SEL_ACTIVE,  // Requests of the selected channel pass.
    SEL_DRAIN    // Switch pending, waiting for an empty port.
  } sel_state_e;

endpackage : hci_pkg

/* logic/hci_core_mux_static.sv */
// Static multiplexer from NB_CHAN initiator ports to one TCDM target port.

`timescale 1ns/100ps

module hci_core_mux_static
  import hci_pkg::*;
#(
  parameter int unsigned NB_CHAN = 2  // Number of initiator channels.
) (
  input  sel_t                 sel_i,         // Channel in force.
  input  logic                 mask_gnt_i,    // Hold off new requests.

  // Initiator side.
  input  logic [NB_CHAN-1:0]   in_req_i,
  input  logic [NB_CHAN-1:0]   in_wen_i,      // High for a read.
  input  addr_t [NB_CHAN-1:0]  in_add_i,
  input  data_t [NB_CHAN-1:0]  in_data_i,
  input  be_t [NB_CHAN-1:0]    in_be_i,
  input  id_t [NB_CHAN-1:0]    in_id_i,
  input  logic [NB_CHAN-1:0]   in_r_ready_i,
  output logic [NB_CHAN-1:0]   in_gnt_o,
  output logic [NB_CHAN-1:0]   in_r_valid_o,
  output data_t                in_r_data_o,   // Shared by all channels.
  output id_t                  in_r_id_o,     // Shared by all channels.

  // Target side.
  output logic                 out_req_o,
  output logic                 out_wen_o,
  output addr_t                out_add_o,
  output data_t                out_data_o,
  output be_t                  out_be_o,
  output id_t                  out_id_o,
  output logic                 out_r_ready_o,
  input  logic                 out_gnt_i,
  input  logic                 out_r_valid_i,
  input  data_t                out_r_data_i,
  input  id_t                  out_r_id_i
);

  // ==========================================================================
  // Request path
  // ==========================================================================

  // A masked request never reaches the bank, so its gnt stays low as well.
  assign out_req_o     = in_req_i[sel_i] & ~mask_gnt_i;
  assign out_wen_o     = in_wen_i[sel_i];
  assign out_add_o     = in_add_i[sel_i];
  assign out_data_o    = in_data_i[sel_i];
  assign out_be_o      = in_be_i[sel_i];
  assign out_id_o      = in_id_i[sel_i];
  assign out_r_ready_o = in_r_ready_i[sel_i];  // Only the owner back-pressures.

  // ==========================================================================
  // Response path
  // ==========================================================================

  for (genvar ii = 0; ii < NB_CHAN; ii++) begin : gen_chan
    assign in_gnt_o[ii]     = (sel_i == ii) ? out_gnt_i     : 1'b0;  // Owner only.
    assign in_r_valid_o[ii] = (sel_i == ii) ? out_r_valid_i : 1'b0;  // Owner only.
  end

  assign in_r_data_o = out_r_data_i;  // Broadcast, qualified by r_valid.
  assign in_r_id_o   = out_r_id_i;    // Broadcast, qualified by r_valid.

endmodule : hci_core_mux_static

/* logic/hci_sel_ctrl.sv */
// Selection controller that counts outstanding transactions and switches when drained.

`timescale 1ns/100ps

module hci_sel_ctrl
  import hci_pkg::*;
(
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  logic  clear_i,          // Synchronous return to the reset state.

  input  sel_t  sel_req_i,        // Requested channel.

  input  logic  bank_gnt_i,       // Bank-side request transfer.
  input  logic  bank_r_valid_i,   // Bank-side response valid.
  input  logic  bank_r_ready_i,   // Bank-side response ready.

  output sel_t  sel_o,            // Channel in force.
  output logic  mask_gnt_o        // Blocks new requests while draining.
);

  sel_state_e          state_q;   // Controller state.
  sel_state_e          state_d;
  logic [OUTST_W-1:0]  outst_q;   // Granted but not yet answered.
  logic                rsp_done;  // Response transfer this cycle.
  logic                switch_en; // Selection loads on this edge.

  assign rsp_done  = bank_r_valid_i & bank_r_ready_i;
  assign switch_en = (state_q == SEL_DRAIN) && (outst_q == '0);

  // ==========================================================================
  // Next state
  // ==========================================================================

  always_comb begin
    state_d = state_q;
    case (state_q)
      SEL_ACTIVE: if (sel_req_i != sel_o) state_d = SEL_DRAIN;  // Switch asked.
      SEL_DRAIN:  if (outst_q == '0)      state_d = SEL_ACTIVE; // Port empty.
      default:                            state_d = SEL_ACTIVE;
    endcase
  end

  // ==========================================================================
  // Registers
  // ==========================================================================

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= SEL_ACTIVE;
      outst_q <= '0;
      sel_o   <= '0;
    end else if (clear_i) begin
      state_q <= SEL_ACTIVE;
      outst_q <= '0;
      sel_o   <= '0;
    end else begin
      state_q <= state_d;
      if (bank_gnt_i && !rsp_done)      outst_q <= outst_q + 1'b1;  // New one in flight.
      else if (!bank_gnt_i && rsp_done) outst_q <= outst_q - 1'b1;  // One retired.
      if (switch_en) sel_o <= sel_req_i;  // Nothing outstanding.
    end
  end

  assign mask_gnt_o = (state_q == SEL_DRAIN);  // No grants during a switch.

endmodule : hci_sel_ctrl

/* logic/tcdm_bank.sv */
// Single-port TCDM word bank with byte enables and a held one-cycle response.

`timescale 1ns/100ps

module tcdm_bank
  import hci_pkg::*;
(
  input  logic   clk_i,
  input  logic   arst_n_i,
  input  logic   clear_i,     // Drops a held response.

  // Request.
  input  logic   req_i,
  input  logic   wen_i,       // High for a read.
  input  addr_t  add_i,       // Byte address.
  input  data_t  data_i,
  input  be_t    be_i,
  input  id_t    id_i,
  output logic   gnt_o,

  // Response.
  output logic   r_valid_o,
  output data_t  r_data_o,
  output id_t    r_id_o,
  input  logic   r_ready_i
);

  data_t                              mem [MEM_WORDS];  // Storage array.
  logic [ADDR_W-$clog2(BE_W)-1:0]     word_idx;         // Word within the bank.
  logic                               r_valid_q;        // Response held.
  data_t                              r_data_q;         // Response payload.
  id_t                                r_id_q;           // Id of the answered request.

  assign word_idx = add_i[ADDR_W-1:$clog2(BE_W)];  // Drop the byte offset.

  // The output register is free, or empties in this very cycle.
  assign gnt_o = req_i & ~clear_i & (~r_valid_q | r_ready_i);

  // ==========================================================================
  // Memory array
  // ==========================================================================

  always_ff @(posedge clk_i) begin
    if (gnt_o && !wen_i) begin
      for (int b = 0; b < BE_W; b++) begin
        if (be_i[b]) mem[word_idx][8*b +: 8] <= data_i[8*b +: 8];  // Enabled bytes.
      end
    end
  end

  // ==========================================================================
  // Response register
  // ==========================================================================

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      r_valid_q <= 1'b0;
    end else if (clear_i) begin
      r_valid_q <= 1'b0;
    end else if (gnt_o) begin
      r_valid_q <= 1'b1;      // Answer follows the grant.
    end else if (r_ready_i) begin
      r_valid_q <= 1'b0;      // Accepted, nothing new.
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      r_data_q <= wen_i ? mem[word_idx] : '0;  // Writes answer with zero.
      r_id_q   <= id_i;                        // Echo the request id.
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;   // Stable while held.
  assign r_id_o    = r_id_q;

endmodule : tcdm_bank

/* logic/hci_static_subsys.sv */
// Top level joining the selection controller, the static multiplexer and the bank.

`timescale 1ns/100ps

module hci_static_subsys
  import hci_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  logic                 clear_i,

  // Selection control.
  input  sel_t                 sel_req_i,
  output sel_t                 cur_sel_o,

  // Initiator channels.
  input  logic [NB_CHAN-1:0]   ch_req_i,
  input  logic [NB_CHAN-1:0]   ch_wen_i,
  input  addr_t [NB_CHAN-1:0]  ch_add_i,
  input  data_t [NB_CHAN-1:0]  ch_data_i,
  input  be_t [NB_CHAN-1:0]    ch_be_i,
  input  id_t [NB_CHAN-1:0]    ch_id_i,
  input  logic [NB_CHAN-1:0]   ch_r_ready_i,
  output logic [NB_CHAN-1:0]   ch_gnt_o,
  output logic [NB_CHAN-1:0]   ch_r_valid_o,
  output data_t                ch_r_data_o,
  output id_t                  ch_r_id_o
);

  // Bank-side port.
  logic   bank_req;
  logic   bank_wen;
  addr_t  bank_add;
  data_t  bank_data;
  be_t    bank_be;
  id_t    bank_id;
  logic   bank_gnt;
  logic   bank_r_valid;
  logic   bank_r_ready;
  data_t  bank_r_data;
  id_t    bank_r_id;
  logic   mask_gnt;   // Switch in progress.

  hci_sel_ctrl hci_sel_ctrl_inst (
    .clk_i, .arst_n_i, .clear_i,
    .sel_req_i,
    .bank_gnt_i     (bank_gnt),
    .bank_r_valid_i (bank_r_valid),
    .bank_r_ready_i (bank_r_ready),
    .sel_o          (cur_sel_o),
    .mask_gnt_o     (mask_gnt)
  );

  hci_core_mux_static #(.NB_CHAN(NB_CHAN)) hci_core_mux_static_inst (
    .sel_i (cur_sel_o), .mask_gnt_i (mask_gnt),
    .in_req_i (ch_req_i), .in_wen_i (ch_wen_i), .in_add_i (ch_add_i),
    .in_data_i (ch_data_i), .in_be_i (ch_be_i), .in_id_i (ch_id_i),
    .in_r_ready_i (ch_r_ready_i), .in_gnt_o (ch_gnt_o), .in_r_valid_o (ch_r_valid_o),
    .in_r_data_o (ch_r_data_o), .in_r_id_o (ch_r_id_o),
    .out_req_o (bank_req), .out_wen_o (bank_wen), .out_add_o (bank_add),
    .out_data_o (bank_data), .out_be_o (bank_be), .out_id_o (bank_id),
    .out_r_ready_o (bank_r_ready), .out_gnt_i (bank_gnt),
    .out_r_valid_i (bank_r_valid), .out_r_data_i (bank_r_data), .out_r_id_i (bank_r_id)
  );

  tcdm_bank tcdm_bank_inst (
    .clk_i, .arst_n_i, .clear_i,
    .req_i (bank_req), .wen_i (bank_wen), .add_i (bank_add),
    .data_i (bank_data), .be_i (bank_be), .id_i (bank_id), .gnt_o (bank_gnt),
    .r_valid_o (bank_r_valid), .r_data_o (bank_r_data), .r_id_o (bank_r_id),
    .r_ready_i (bank_r_ready)
  );

endmodule : hci_static_subsys

/* verif/hci_static_subsys_props.sv */
// Concurrent handshake properties of the static HCI subsystem and their bind.

`timescale 1ns/100ps

module hci_static_subsys_props
  import hci_pkg::*;
(
  input logic                clk_i,
  input logic                arst_n_i,
  input logic                clear_i,
  input sel_t                cur_sel_i,
  input logic [NB_CHAN-1:0]  ch_gnt_i,
  input logic                bank_gnt_i,
  input logic                bank_r_valid_i,
  input logic                bank_r_ready_i,
  input data_t               bank_r_data_i,
  input id_t                 bank_r_id_i
);

  // A stalled response stays valid and unchanged.
  held_rsp_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bank_r_valid_i && !bank_r_ready_i && !clear_i |=>
      bank_r_valid_i && $stable(bank_r_data_i) && $stable(bank_r_id_i))
    else $error("held response changed or dropped before r_ready");

  one_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i) $onehot0(ch_gnt_i))
    else $error("gnt seen on more than one channel");

  // An empty port has no held response, and no grant while draining.
  sel_switch_drained: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (cur_sel_i != $past(cur_sel_i)) && !$past(clear_i) |->
      !$past(bank_r_valid_i) && !$past(bank_gnt_i))
    else $error("selection changed with a transaction outstanding");

endmodule : hci_static_subsys_props

bind hci_static_subsys hci_static_subsys_props hci_static_subsys_props_inst (
  .clk_i, .arst_n_i, .clear_i,
  .cur_sel_i (cur_sel_o), .ch_gnt_i (ch_gnt_o), .bank_gnt_i (bank_gnt),
  .bank_r_valid_i (bank_r_valid), .bank_r_ready_i (bank_r_ready),
  .bank_r_data_i (bank_r_data), .bank_r_id_i (bank_r_id)
);

/* verif/hci_static_subsys_tb.sv */
// Testbench for the static HCI subsystem with random traffic, reference memory and report.

`timescale 1ns/100ps

module hci_static_subsys_tb
  import hci_pkg::*;
();

  localparam int TIMEOUT = 200;  // Cycles allowed for any single wait.
  localparam int N_RAW   = 16;   // Words per read-after-write pass.

  logic                clk;
  logic                arst_n;
  logic                clear;
  sel_t                sel_req;
  sel_t                cur_sel;
  logic [NB_CHAN-1:0]  ch_req;
  logic [NB_CHAN-1:0]  ch_wen;
  addr_t [NB_CHAN-1:0] ch_add;
  data_t [NB_CHAN-1:0] ch_data;
  be_t [NB_CHAN-1:0]   ch_be;
  id_t [NB_CHAN-1:0]   ch_id;
  logic [NB_CHAN-1:0]  ch_r_ready;
  logic [NB_CHAN-1:0]  ch_gnt;
  logic [NB_CHAN-1:0]  ch_r_valid;
  data_t               ch_r_data;
  id_t                 ch_r_id;

  data_t ref_mem [MEM_WORDS];   // Reference memory.
  sel_t  exp_ch_q [$];          // Expected responses in grant order.
  id_t   exp_id_q [$];
  data_t exp_data_q [$];
  int    err_cnt;
  int    rsp_cnt;               // Responses compared.
  int    seed;
  int    rdy_mode;              // 0 ready, 1 stalled, 2 random gaps.
  int    rnd_word;
  string test_name;
  sel_t  last_sel;
  logic  held_prev;             // Response stalled in the last cycle.
  data_t held_data;
  id_t   held_id;

  hci_static_subsys hci_static_subsys_inst (
    .clk_i (clk), .arst_n_i (arst_n), .clear_i (clear),
    .sel_req_i (sel_req), .cur_sel_o (cur_sel),
    .ch_req_i (ch_req), .ch_wen_i (ch_wen), .ch_add_i (ch_add),
    .ch_data_i (ch_data), .ch_be_i (ch_be), .ch_id_i (ch_id),
    .ch_r_ready_i (ch_r_ready), .ch_gnt_o (ch_gnt), .ch_r_valid_o (ch_r_valid),
    .ch_r_data_o (ch_r_data), .ch_r_id_o (ch_r_id)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period.
  end

  always @(posedge clk) begin
    rnd_word = $random(seed);
    case (rdy_mode)
      0:       ch_r_ready <= '1;
      1:       ch_r_ready <= '0;
      default: ch_r_ready <= rnd_word[NB_CHAN-1:0];  // Random gaps.
    endcase
  end

  // ==========================================================================
  // Monitor and checks
  // ==========================================================================

  always @(posedge clk) begin : monitor
    sel_t s;
    int   idx;
    s = cur_sel;
    if (!arst_n) begin
      held_prev = 1'b0;
      last_sel  = '0;
    end else begin
      if (s != last_sel) begin  // Switch must follow a drained port.
        assert (exp_ch_q.size() == 0) else begin
          err_cnt++;
          $display("%s: selection changed with %0d responses outstanding",
                   test_name, exp_ch_q.size());
        end
      end
      last_sel = s;
      for (int c = 0; c < NB_CHAN; c++) begin
        if (sel_t'(c) != s) begin
          assert (!ch_gnt[c] && !ch_r_valid[c]) else begin
            err_cnt++;
            $display("%s: unselected channel %0d saw gnt or r_valid", test_name, c);
          end
        end
      end
      if (held_prev) begin  // Stalled response stays put.
        assert (ch_r_valid[s]) else begin
          err_cnt++;
          $display("%s: response dropped before r_ready", test_name);
        end
        assert (ch_r_data == held_data && ch_r_id == held_id) else begin
          err_cnt++;
          $display("MISMATCH %s held response: expected %h/%h actual %h/%h",
                   test_name, held_data, held_id, ch_r_data, ch_r_id);
        end
      end
      if (ch_r_valid[s] && !ch_r_ready[s]) begin
        assert (ch_gnt == '0) else begin
          err_cnt++;
          $display("%s: gnt while a response was stalled", test_name);
        end
      end
      if (ch_r_valid[s] && ch_r_ready[s]) begin  // Response transfer.
        assert (exp_ch_q.size() > 0) else begin
          err_cnt++;
          $display("%s: response with no request outstanding", test_name);
        end
        if (exp_ch_q.size() > 0) begin
          rsp_cnt++;
          assert (exp_ch_q[0] == s) else begin
            err_cnt++;
            $display("MISMATCH %s response channel: expected %0d actual %0d",
                     test_name, exp_ch_q[0], s);
          end
          assert (ch_r_data == exp_data_q[0]) else begin
            err_cnt++;
            $display("MISMATCH %s r_data: expected %h actual %h",
                     test_name, exp_data_q[0], ch_r_data);
          end
          assert (ch_r_id == exp_id_q[0]) else begin
            err_cnt++;
            $display("MISMATCH %s r_id: expected %0d actual %0d",
                     test_name, exp_id_q[0], ch_r_id);
          end
          void'(exp_ch_q.pop_front());
          void'(exp_id_q.pop_front());
          void'(exp_data_q.pop_front());
        end
      end
      if (ch_gnt[s]) begin  // Request transfer.
        idx = int'(ch_add[s][ADDR_W-1:2]);
        exp_ch_q.push_back(s);
        exp_id_q.push_back(ch_id[s]);
        if (ch_wen[s]) begin
          exp_data_q.push_back(ref_mem[idx]);  // Read sees the model word.
        end else begin
          exp_data_q.push_back(data_t'(0));    // Writes answer with zero.
          for (int b = 0; b < BE_W; b++) begin
            if (ch_be[s][b]) ref_mem[idx][8*b +: 8] = ch_data[s][8*b +: 8];
          end
        end
      end
      held_prev = ch_r_valid[s] && !ch_r_ready[s] && !clear;
      held_data = ch_r_data;
      held_id   = ch_r_id;
    end
  end

  // ==========================================================================
  // Helpers
  // ==========================================================================

  task automatic fail_timeout(input string what);
    err_cnt++;
    $display("%s: timed out waiting for %s", test_name, what);
    $display("errors: %0d, responses checked: %0d", err_cnt, rsp_cnt);
    $display("tests failed");
    $finish;
  endtask

  function automatic data_t fill_word(input int w);
    return (data_t'(w) * 32'h0101_0101) ^ 32'hC3A5_5A3C;  // Unique per word.
  endfunction

  task automatic issue(input int ch, input logic wen, input addr_t add,
                       input data_t data, input be_t be, input id_t id);
    int t;
    @(posedge clk);
    ch_req[ch]  <= 1'b1;
    ch_wen[ch]  <= wen;
    ch_add[ch]  <= add;
    ch_data[ch] <= data;
    ch_be[ch]   <= be;
    ch_id[ch]   <= id;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!ch_gnt[ch] && t < TIMEOUT);
    if (!ch_gnt[ch]) fail_timeout("gnt");
    ch_req[ch] <= 1'b0;  // Transferred, drop it.
  endtask

  task automatic random_op(input int ch);
    logic wen;
    wen = $random(seed);
    issue(ch, wen, addr_t'($random(seed)), data_t'($random(seed)),
          be_t'($random(seed)), id_t'($random(seed)));
  endtask

  task automatic wait_drained();
    int t;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (exp_ch_q.size() != 0 && t < TIMEOUT);
    if (exp_ch_q.size() != 0) fail_timeout("responses to drain");
  endtask

  task automatic select_channel(input int ch);
    int t;
    @(posedge clk);
    sel_req <= sel_t'(ch);
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (cur_sel != sel_t'(ch) && t < TIMEOUT);
    if (cur_sel != sel_t'(ch)) fail_timeout("selection switch");
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================

  initial begin : stimulus
    addr_t raw_add [N_RAW];
    addr_t a;
    seed = 32'h5f72c18a;
    err_cnt = 0;
    rsp_cnt = 0;
    rdy_mode = 0;
    test_name = "reset";
    arst_n = 1'b0;
    clear = 1'b0;
    sel_req = '0;
    ch_req = '0;
    ch_wen = '0;
    ch_add = '0;
    ch_data = '0;
    ch_be = '0;
    ch_id = '0;
    ch_r_ready = '1;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;

    test_name = "fill";  // Every word gets a known value first.
    for (int w = 0; w < MEM_WORDS; w++) issue(0, 1'b0, addr_t'(w * 4), fill_word(w), '1, id_t'(w));
    wait_drained();

    test_name = "read_after_write";
    for (int ch = 0; ch < NB_CHAN; ch++) begin
      select_channel(ch);
      for (int k = 0; k < N_RAW; k++) begin
        raw_add[k] = addr_t'($random(seed));
        issue(ch, 1'b0, raw_add[k], data_t'($random(seed)), be_t'($random(seed)),
              id_t'($random(seed)));
      end
      for (int k = 0; k < N_RAW; k++) issue(ch, 1'b1, raw_add[k], '0, '0, id_t'(k));
      wait_drained();
    end

    test_name = "isolation";
    select_channel(0);
    a = addr_t'($random(seed));
    ch_req[1]  <= 1'b1;  // Channel 1 keeps knocking.
    ch_wen[1]  <= 1'b0;
    ch_add[1]  <= a;
    ch_data[1] <= ~ref_mem[a[ADDR_W-1:2]];
    ch_be[1]   <= '1;
    for (int k = 0; k < 20; k++) random_op(0);
    issue(0, 1'b1, a, '0, '0, 2'd3);
    ch_req[1] <= 1'b0;
    wait_drained();

    test_name = "deferred_switch";
    rdy_mode = 1;
    issue(0, 1'b1, raw_add[0], '0, '0, 2'd1);  // Response now stalled.
    sel_req <= 1'b1;
    repeat (8) begin
      @(posedge clk);
      assert (cur_sel == 1'b0) else begin
        err_cnt++;
        $display("MISMATCH %s cur_sel: expected 0 actual %0d", test_name, cur_sel);
      end
    end
    rdy_mode = 0;
    select_channel(1);
    issue(1, 1'b1, raw_add[1], '0, '0, 2'd2);
    wait_drained();

    test_name = "backpressure";
    rdy_mode = 2;
    for (int k = 0; k < 30; k++) random_op(1);
    select_channel(0);
    for (int k = 0; k < 30; k++) random_op(0);
    rdy_mode = 0;
    wait_drained();

    test_name = "id_echo";
    for (int k = 0; k < 8; k++) issue(0, 1'b1, raw_add[k], '0, '0, id_t'(k));
    wait_drained();

    test_name = "clear";
    select_channel(1);
    rdy_mode = 1;
    issue(1, 1'b1, raw_add[2], '0, '0, 2'd0);  // Left stalled, clear drops it.
    clear   <= 1'b1;
    sel_req <= 1'b0;
    @(posedge clk);
    clear <= 1'b0;
    exp_ch_q.delete();
    exp_id_q.delete();
    exp_data_q.delete();
    @(posedge clk);
    assert (cur_sel == 1'b0 && ch_r_valid == '0) else begin
      err_cnt++;
      $display("MISMATCH %s sel/r_valid: expected 0/0 actual %0d/%b",
               test_name, cur_sel, ch_r_valid);
    end
    rdy_mode = 0;
    for (int k = 0; k < N_RAW; k++) issue(0, 1'b1, raw_add[k], '0, '0, id_t'(k));
    wait_drained();

    $display("errors: %0d, responses checked: %0d", err_cnt, rsp_cnt);
    if (err_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule : hci_static_subsys_tb

/* build.f */
logic/hci_pkg.sv
logic/hci_core_mux_static.sv
logic/hci_sel_ctrl.sv
logic/tcdm_bank.sv
logic/hci_static_subsys.sv
verif/hci_static_subsys_props.sv
verif/hci_static_subsys_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log.
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module hci_static_subsys_tb

./obj_dir/Vhci_static_subsys_tb 2>&1 | tee "$LOG"

if grep -q "tests failed" "$LOG"; then
  echo "simulation reported failures"
  exit 1
fi
if ! grep -q "all tests passed" "$LOG"; then
  echo "simulation ended without a verdict"
  exit 1
fi
echo "simulation clean"
